//--- src/rv_isa_pkg.sv
package rv_isa_pkg;

    // major opcodes in instr[6:0]
    typedef enum logic [6:0] {
        op     = 7'b0110011,
        op_imm = 7'b0010011,
        lui    = 7'b0110111,
        auipc  = 7'b0010111,
        jal    = 7'b1101111,
        jalr   = 7'b1100111,
        branch = 7'b1100011,
        system = 7'b1110011
    } rv_opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and,
        alu_pass_b    // lui
    } alu_op_e;

    // branch compare codes
    localparam logic [2:0] beq  = 3'b000;
    localparam logic [2:0] bne  = 3'b001;
    localparam logic [2:0] blt  = 3'b100;
    localparam logic [2:0] bge  = 3'b101;
    localparam logic [2:0] bltu = 3'b110;
    localparam logic [2:0] bgeu = 3'b111;

    localparam logic [31:0] ebreak_word = 32'h0010_0073;

    // r-type layout shared by the other formats
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_fields_t;

endpackage

//--- src/core_regmap_pkg.sv
package core_regmap_pkg;

    localparam logic [7:0] ctrl_off      = 8'h00;
    localparam logic [7:0] start_pc_off  = 8'h04;
    localparam logic [7:0] status_off    = 8'h08;
    localparam logic [7:0] retired_off   = 8'h0C;
    localparam logic [7:0] imem_addr_off = 8'h10;
    localparam logic [7:0] imem_data_off = 8'h14;
    localparam logic [7:0] regwin_base   = 8'h80;  // x0..x31 at 0x80..0xfc

    // status bits
    localparam int busy_bit    = 0;
    localparam int halted_bit  = 1;
    localparam int illegal_bit = 2;

    typedef enum logic [2:0] {
        idle,
        fetch,
        execute,
        writeback,
        halt
    } seq_state_e;

endpackage

//--- src/instr_decoder.sv
`timescale 1ns/10ps

module instr_decoder (
    input  logic [31:0]         instr,
    output logic [4:0]          rs1_index,
    output logic [4:0]          rs2_index,
    output logic [4:0]          rd_index,
    output logic [31:0]         imm,
    output rv_isa_pkg::alu_op_e alu_op,
    output logic                use_imm,
    output logic                use_pc,
    output logic                rd_write,
    output logic                is_branch,
    output logic                is_jal,
    output logic                is_jalr,
    output logic                is_ebreak,
    output logic                is_illegal
);

    rv_isa_pkg::instr_fields_t f;
    rv_isa_pkg::alu_op_e       f3_op;
    logic [31:0]               imm_i;
    logic [31:0]               imm_u;
    logic [31:0]               imm_j;
    logic [31:0]               imm_b;
    logic                      alt;

    assign f         = instr;
    assign rs1_index = f.rs1;
    assign rs2_index = f.rs2;
    assign rd_index  = f.rd;
    assign alt       = f.funct7[5];  // sub / sra select

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    assign imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

    always_comb begin
        case (f.funct3)
            3'b000:  f3_op = alt ? rv_isa_pkg::alu_sub : rv_isa_pkg::alu_add;
            3'b001:  f3_op = rv_isa_pkg::alu_sll;
            3'b010:  f3_op = rv_isa_pkg::alu_slt;
            3'b011:  f3_op = rv_isa_pkg::alu_sltu;
            3'b100:  f3_op = rv_isa_pkg::alu_xor;
            3'b101:  f3_op = alt ? rv_isa_pkg::alu_sra : rv_isa_pkg::alu_srl;
            3'b110:  f3_op = rv_isa_pkg::alu_or;
            default: f3_op = rv_isa_pkg::alu_and;
        endcase
    end

    always_comb begin
        imm        = imm_i;
        alu_op     = rv_isa_pkg::alu_add;
        use_imm    = 1'b0;
        use_pc     = 1'b0;
        rd_write   = 1'b0;
        is_branch  = 1'b0;
        is_jal     = 1'b0;
        is_jalr    = 1'b0;
        is_ebreak  = 1'b0;
        is_illegal = 1'b0;
        case (f.opcode)
            rv_isa_pkg::op: begin
                alu_op   = f3_op;
                rd_write = 1'b1;
                // funct7 0x20 only valid for sub and sra
                if (f.funct7 != 7'h00 &&
                    !(f.funct7 == 7'h20 && (f.funct3 == 3'b000 || f.funct3 == 3'b101)))
                    is_illegal = 1'b1;
            end
            rv_isa_pkg::op_imm: begin
                alu_op   = (f.funct3 == 3'b000) ? rv_isa_pkg::alu_add : f3_op;
                use_imm  = 1'b1;
                rd_write = 1'b1;
                if (f.funct3 == 3'b001 && f.funct7 != 7'h00)
                    is_illegal = 1'b1;
                if (f.funct3 == 3'b101 && f.funct7 != 7'h00 && f.funct7 != 7'h20)
                    is_illegal = 1'b1;
            end
            rv_isa_pkg::lui: begin
                imm      = imm_u;
                alu_op   = rv_isa_pkg::alu_pass_b;
                use_imm  = 1'b1;
                rd_write = 1'b1;
            end
            rv_isa_pkg::auipc: begin
                imm      = imm_u;
                use_imm  = 1'b1;
                use_pc   = 1'b1;
                rd_write = 1'b1;
            end
            rv_isa_pkg::jal: begin
                imm      = imm_j;  // alu forms pc+imm target
                use_imm  = 1'b1;
                use_pc   = 1'b1;
                rd_write = 1'b1;
                is_jal   = 1'b1;
            end
            rv_isa_pkg::jalr: begin
                use_imm    = 1'b1;
                rd_write   = 1'b1;
                is_jalr    = 1'b1;
                is_illegal = (f.funct3 != 3'b000);
            end
            rv_isa_pkg::branch: begin
                imm       = imm_b;
                is_branch = 1'b1;
                case (f.funct3)
                    rv_isa_pkg::beq, rv_isa_pkg::bne:   alu_op = rv_isa_pkg::alu_sub;
                    rv_isa_pkg::blt, rv_isa_pkg::bge:   alu_op = rv_isa_pkg::alu_slt;
                    rv_isa_pkg::bltu, rv_isa_pkg::bgeu: alu_op = rv_isa_pkg::alu_sltu;
                    default:                            is_illegal = 1'b1;
                endcase
            end
            rv_isa_pkg::system: begin
                is_ebreak  = (instr == rv_isa_pkg::ebreak_word);
                is_illegal = (instr != rv_isa_pkg::ebreak_word);
            end
            default: is_illegal = 1'b1;  // loads, stores, fence, ...
        endcase
    end

endmodule

//--- src/alu.sv
`timescale 1ns/10ps

module alu (
    input  rv_isa_pkg::alu_op_e alu_op,
    input  logic [2:0]          funct3,
    input  logic [31:0]         a,
    input  logic [31:0]         b,
    output logic [31:0]         result,
    output logic                taken
);

    always_comb begin
        case (alu_op)
            rv_isa_pkg::alu_add:    result = a + b;
            rv_isa_pkg::alu_sub:    result = a - b;
            rv_isa_pkg::alu_sll:    result = a << b[4:0];
            rv_isa_pkg::alu_slt:    result = {31'b0, $signed(a) < $signed(b)};
            rv_isa_pkg::alu_sltu:   result = {31'b0, a < b};
            rv_isa_pkg::alu_xor:    result = a ^ b;
            rv_isa_pkg::alu_srl:    result = a >> b[4:0];
            rv_isa_pkg::alu_sra:    result = $signed(a) >>> b[4:0];
            rv_isa_pkg::alu_or:     result = a | b;
            rv_isa_pkg::alu_and:    result = a & b;
            rv_isa_pkg::alu_pass_b: result = b;
            default:                result = '0;
        endcase
    end

    // branch decision from the compare result
    always_comb begin
        case (funct3)
            rv_isa_pkg::beq:                    taken = (result == '0);
            rv_isa_pkg::bne:                    taken = (result != '0);
            rv_isa_pkg::blt, rv_isa_pkg::bltu:  taken = result[0];
            rv_isa_pkg::bge, rv_isa_pkg::bgeu:  taken = !result[0];
            default:                            taken = 1'b0;
        endcase
    end

endmodule

//--- src/register_file.sv
`timescale 1ns/10ps

module register_file (
    input  logic        clk,
    input  logic        reset,
    input  logic [4:0]  rs1_index,
    input  logic [4:0]  rs2_index,
    input  logic [4:0]  dbg_index,
    output logic [31:0] rs1_data,
    output logic [31:0] rs2_data,
    output logic [31:0] dbg_data,
    input  logic        rd_we,
    input  logic [4:0]  rd_index,
    input  logic [31:0] rd_data
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end else if (rd_we && rd_index != 5'd0) begin  // x0 never written
            regs[rd_index] <= rd_data;
        end
    end

    assign rs1_data = regs[rs1_index];
    assign rs2_data = regs[rs2_index];
    assign dbg_data = regs[dbg_index];

endmodule

//--- src/core_sequencer.sv
`timescale 1ns/10ps

module core_sequencer #(
    parameter int imem_depth = 64
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start,
    input  logic [31:0]                   start_pc,
    input  logic                          imem_we,
    input  logic [$clog2(imem_depth)-1:0] imem_waddr,
    input  logic [31:0]                   imem_wdata,
    output logic [31:0]                   instr,
    input  logic [4:0]                    dec_rd_index,
    input  logic [31:0]                   imm,
    input  rv_isa_pkg::alu_op_e           dec_alu_op,
    input  logic                          use_imm,
    input  logic                          use_pc,
    input  logic                          rd_write,
    input  logic                          is_branch,
    input  logic                          is_jal,
    input  logic                          is_jalr,
    input  logic                          is_ebreak,
    input  logic                          is_illegal,
    input  logic [31:0]                   rs1_data,
    input  logic [31:0]                   rs2_data,
    output logic [31:0]                   a,
    output logic [31:0]                   b,
    output rv_isa_pkg::alu_op_e           alu_op,
    input  logic [31:0]                   result,
    input  logic                          taken,
    output logic                          rd_we,
    output logic [4:0]                    rd_index,
    output logic [31:0]                   rd_data,
    output logic                          busy,
    output logic                          halted,
    output logic                          illegal,
    output logic [31:0]                   retired
);

    localparam int aw = $clog2(imem_depth);
    localparam logic [31:0] pc_mask = 32'(imem_depth * 4 - 4);  // word aligned with wrap

    core_regmap_pkg::seq_state_e state;
    logic [31:0] imem [imem_depth];
    logic [31:0] pc;
    logic [31:0] pc_plus4;
    logic [31:0] target;
    logic [31:0] next_pc;
    logic [31:0] wb_data;

    always_ff @(posedge clk) begin
        if (imem_we)
            imem[imem_waddr] <= imem_wdata;
    end

    assign pc_plus4 = pc + 32'd4;

    always_comb begin
        if (is_jal || is_jalr)
            target = {result[31:1], 1'b0};
        else if (is_branch && taken)
            target = pc + imm;
        else
            target = pc_plus4;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state   <= core_regmap_pkg::idle;
            pc      <= '0;
            illegal <= 1'b0;
            retired <= '0;
        end else begin
            case (state)
                core_regmap_pkg::idle, core_regmap_pkg::halt: begin
                    if (start) begin
                        pc      <= start_pc & pc_mask;
                        illegal <= 1'b0;
                        retired <= '0;
                        state   <= core_regmap_pkg::fetch;
                    end
                end
                core_regmap_pkg::fetch: state <= core_regmap_pkg::execute;
                core_regmap_pkg::execute: begin
                    if (is_ebreak || is_illegal) begin
                        illegal <= is_illegal;
                        state   <= core_regmap_pkg::halt;  // not counted
                    end else begin
                        state <= core_regmap_pkg::writeback;
                    end
                end
                core_regmap_pkg::writeback: begin
                    pc      <= next_pc;
                    retired <= retired + 32'd1;
                    state   <= core_regmap_pkg::fetch;
                end
                default: state <= core_regmap_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == core_regmap_pkg::fetch)
            instr <= imem[pc[aw+1:2]];
        if (state == core_regmap_pkg::execute) begin
            wb_data <= (is_jal || is_jalr) ? pc_plus4 : result;  // link value for jumps
            next_pc <= target & pc_mask;
        end
    end

    assign a        = use_pc ? pc : rs1_data;
    assign b        = use_imm ? imm : rs2_data;
    assign alu_op   = dec_alu_op;
    assign rd_we    = (state == core_regmap_pkg::writeback) && rd_write;
    assign rd_index = dec_rd_index;
    assign rd_data  = wb_data;

    assign busy   = state inside {core_regmap_pkg::fetch, core_regmap_pkg::execute,
                                  core_regmap_pkg::writeback};
    assign halted = (state == core_regmap_pkg::halt);

endmodule

//--- src/core_ctrl_apb.sv
`timescale 1ns/10ps

module core_ctrl_apb #(
    parameter int imem_depth = 64
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          psel,
    input  logic                          penable,
    input  logic                          pwrite,
    input  logic [7:0]                    paddr,
    input  logic [31:0]                   pwdata,
    output logic [31:0]                   prdata,
    output logic                          pready,
    output logic                          pslverr,
    output logic                          start,
    output logic [31:0]                   start_pc,
    output logic                          imem_we,
    output logic [$clog2(imem_depth)-1:0] imem_waddr,
    output logic [31:0]                   imem_wdata,
    input  logic                          busy,
    input  logic                          halted,
    input  logic                          illegal,
    input  logic [31:0]                   retired,
    output logic [4:0]                    dbg_index,
    input  logic [31:0]                   dbg_data
);

    localparam int aw = $clog2(imem_depth);

    logic        access;
    logic        wr;
    logic        mapped;
    logic        locked;
    logic [31:0] status;
    logic [31:0] rdata;

    assign access    = psel && penable;
    assign wr        = access && pwrite;
    assign dbg_index = paddr[6:2];  // register window slot

    always_comb begin
        status = '0;
        status[core_regmap_pkg::busy_bit]    = busy;
        status[core_regmap_pkg::halted_bit]  = halted;
        status[core_regmap_pkg::illegal_bit] = illegal;
    end

    always_comb begin
        mapped = (paddr[1:0] == 2'b00);
        rdata  = '0;
        if (paddr >= core_regmap_pkg::regwin_base) begin
            rdata = dbg_data;
        end else begin
            case (paddr)
                core_regmap_pkg::ctrl_off:      rdata = '0;
                core_regmap_pkg::imem_data_off: rdata = '0;  // write only
                core_regmap_pkg::start_pc_off:  rdata = start_pc;
                core_regmap_pkg::status_off:    rdata = status;
                core_regmap_pkg::retired_off:   rdata = retired;
                core_regmap_pkg::imem_addr_off: rdata = 32'(imem_waddr);
                default:                        mapped = 1'b0;
            endcase
        end
    end

    // loader and start pc are frozen during a run
    assign locked = busy && (paddr == core_regmap_pkg::imem_data_off ||
                             paddr == core_regmap_pkg::start_pc_off);

    assign pready  = 1'b1;
    assign pslverr = access && (!mapped || (pwrite && locked));
    assign prdata  = (access && !pwrite) ? rdata : '0;

    assign start      = wr && paddr == core_regmap_pkg::ctrl_off && pwdata[0] && !busy;
    assign imem_we    = wr && paddr == core_regmap_pkg::imem_data_off && !busy;
    assign imem_wdata = pwdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            start_pc   <= '0;
            imem_waddr <= '0;
        end else begin
            if (wr && paddr == core_regmap_pkg::start_pc_off && !busy)
                start_pc <= pwdata;
            if (wr && paddr == core_regmap_pkg::imem_addr_off)
                imem_waddr <= pwdata[aw-1:0];
            else if (imem_we)
                imem_waddr <= imem_waddr + 1'b1;  // auto increment
        end
    end

endmodule

//--- src/rv_core_top.sv
`timescale 1ns/10ps

module rv_core_top #(
    parameter int imem_depth = 64
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [7:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    localparam int aw = $clog2(imem_depth);

    logic          start, imem_we, busy, halted, illegal;
    logic [31:0]   start_pc, imem_wdata, retired, dbg_data;
    logic [aw-1:0] imem_waddr;
    logic [4:0]    dbg_index, rs1_index, rs2_index, dec_rd_index, rd_index;
    logic [31:0]   instr, imm, rs1_data, rs2_data, a, b, result, rd_data;
    logic          use_imm, use_pc, rd_write, is_branch, is_jal, is_jalr;
    logic          is_ebreak, is_illegal, taken, rd_we;
    rv_isa_pkg::alu_op_e dec_alu_op, alu_op;

    core_ctrl_apb #(.imem_depth(imem_depth)) i_ctrl (
        .clk(clk), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .start(start), .start_pc(start_pc), .imem_we(imem_we),
        .imem_waddr(imem_waddr), .imem_wdata(imem_wdata),
        .busy(busy), .halted(halted), .illegal(illegal), .retired(retired),
        .dbg_index(dbg_index), .dbg_data(dbg_data)
    );

    core_sequencer #(.imem_depth(imem_depth)) i_seq (
        .clk(clk), .reset(reset),
        .start(start), .start_pc(start_pc), .imem_we(imem_we),
        .imem_waddr(imem_waddr), .imem_wdata(imem_wdata), .instr(instr),
        .dec_rd_index(dec_rd_index), .imm(imm), .dec_alu_op(dec_alu_op),
        .use_imm(use_imm), .use_pc(use_pc), .rd_write(rd_write),
        .is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr),
        .is_ebreak(is_ebreak), .is_illegal(is_illegal),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .a(a), .b(b), .alu_op(alu_op),
        .result(result), .taken(taken),
        .rd_we(rd_we), .rd_index(rd_index), .rd_data(rd_data),
        .busy(busy), .halted(halted), .illegal(illegal), .retired(retired)
    );

    instr_decoder i_dec (
        .instr(instr), .rs1_index(rs1_index), .rs2_index(rs2_index),
        .rd_index(dec_rd_index), .imm(imm), .alu_op(dec_alu_op),
        .use_imm(use_imm), .use_pc(use_pc), .rd_write(rd_write),
        .is_branch(is_branch), .is_jal(is_jal), .is_jalr(is_jalr),
        .is_ebreak(is_ebreak), .is_illegal(is_illegal)
    );

    alu i_alu (
        .alu_op(alu_op), .funct3(instr[14:12]), .a(a), .b(b),
        .result(result), .taken(taken)
    );

    register_file i_rf (
        .clk(clk), .reset(reset),
        .rs1_index(rs1_index), .rs2_index(rs2_index), .dbg_index(dbg_index),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .dbg_data(dbg_data),
        .rd_we(rd_we), .rd_index(rd_index), .rd_data(rd_data)
    );

endmodule

//--- verif/rv_core_assert.sv
`timescale 1ns/10ps

module rv_core_assert (
    input logic clk,
    input logic reset,
    input logic psel,
    input logic penable,
    input logic illegal,
    input logic busy,
    input logic halted,
    input logic start
);

    // illegal flag only lives in the halt state
    illegal_only_halted: assert property (@(posedge clk) disable iff (reset) illegal |-> halted)
        else $error("illegal flag set outside halt");

    penable_with_psel: assert property (@(posedge clk) disable iff (reset) penable |-> psel)
        else $error("penable high without psel");

    busy_halted_excl: assert property (@(posedge clk) disable iff (reset) !(busy && halted))
        else $error("busy and halted both high");

    // a start pulse launches a run on the next clock
    start_then_busy: assert property (@(posedge clk) disable iff (reset) start |=> busy)
        else $error("start pulse did not launch a run");

endmodule

bind core_ctrl_apb rv_core_assert i_apb_assert (
    .clk(clk), .reset(reset), .psel(psel), .penable(penable), .illegal(illegal),
    .busy(busy), .halted(halted), .start(start)
);

//--- verif/rv_core_tb.sv
`timescale 1ns/10ps

module rv_core_tb;

    // about 40 retired instructions x 3 clocks plus roughly 150 apb transfers
    // x 3 clocks and the status polling, rounded up generously
    localparam int max_cycles = 4000;

    logic        clk;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    int cycles = 0;
    int pass_count = 0;
    int fail_count = 0;
    int test_mark = 0;
    int fd;

    rv_core_top #(.imem_depth(64)) i_dut (
        .clk(clk), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("ERROR: timeout, the run did not finish within %0d cycles", max_cycles);
            $display("Something failed");
            $finish;
        end
    end

    task check_value(input logic [31:0] actual, input logic [31:0] expected, input string what);
        if (actual !== expected) begin
            $display("FAIL %0t ns: %0s, got %h, expected %h", $time, what, actual, expected);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    // setup and access on consecutive falling edges with the sample in the low phase
    task apb_write(input logic [7:0] off, input logic [31:0] data, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = off;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        #10;
        err = pslverr;
        check_value({31'b0, pready}, 32'd1, "pready in write access");
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task apb_read(input logic [7:0] off, output logic [31:0] data, output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = off;
        @(negedge clk);
        penable = 1'b1;
        #10;
        data = prdata;
        err  = pslverr;
        check_value({31'b0, pready}, 32'd1, "pready in read access");
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task wait_halted;
        logic [31:0] st;
        logic        err;
        st = '0;
        while (!st[core_regmap_pkg::halted_bit]) begin
            apb_read(core_regmap_pkg::status_off, st, err);
        end
    endtask

    // loader address first and then the words through the auto-incrementing data port
    task load_program(input logic [31:0] word_addr, input logic [31:0] count);
        logic [31:0] word;
        logic        err;
        int          n;
        apb_write(core_regmap_pkg::imem_addr_off, word_addr, err);
        check_value({31'b0, err}, 32'd0, "pslverr of loader address write");
        for (int i = 0; i < count; i++) begin
            n = $fscanf(fd, "%h", word);
            if (n != 1) begin
                $display("ERROR: program word %0d is missing in the stim file", i);
                fail_count++;
            end
            apb_write(core_regmap_pkg::imem_data_off, word, err);
            check_value({31'b0, err}, 32'd0, "pslverr of program word write");
        end
    endtask

    task report_test(input logic [8*32-1:0] name);
        int errs;
        errs = fail_count - test_mark;
        $display("test %0s: %0s, %0d failed checks", name, (errs == 0) ? "passed" : "failed", errs);
        test_mark = fail_count;
    endtask

    task run_stim;
        logic [8*16-1:0]  cmd;
        logic [8*32-1:0]  name;
        logic [8*256-1:0] line;
        logic [31:0]      off;
        logic [31:0]      data;
        logic [31:0]      exp_err;
        logic [31:0]      rdata;
        logic             err;
        logic             done;
        int               n;
        done = 1'b0;
        while (!done) begin
            cmd = '0;
            n = $fscanf(fd, "%s", cmd);
            if (n != 1) begin
                done = 1'b1;
            end else if (cmd == "#") begin
                n = $fgets(line, fd);  // rest of a comment line
            end else if (cmd == "W") begin
                n = $fscanf(fd, "%h %h %h", off, data, exp_err);
                apb_write(off[7:0], data, err);
                check_value({31'b0, err}, exp_err, $sformatf("pslverr of write to %h", off[7:0]));
            end else if (cmd == "R") begin
                n = $fscanf(fd, "%h %h %h", off, data, exp_err);
                apb_read(off[7:0], rdata, err);
                check_value(rdata, data, $sformatf("read of %h", off[7:0]));
                check_value({31'b0, err}, exp_err, $sformatf("pslverr of read of %h", off[7:0]));
            end else if (cmd == "L") begin
                n = $fscanf(fd, "%h %h", off, data);
                load_program(off, data);
            end else if (cmd == "H") begin
                wait_halted();
            end else if (cmd == "T") begin
                n = $fscanf(fd, "%s", name);
                report_test(name);
            end else begin
                $display("ERROR: unknown command %0s in the stim file", cmd);
                fail_count++;
            end
        end
    endtask

    initial begin
        clk     = 1'b0;
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (4) @(negedge clk);
        reset = 1'b0;
        fd = $fopen("verif/rv_core_stim.txt", "r");
        if (fd == 0) begin
            $display("ERROR: could not open the stim file verif/rv_core_stim.txt");
            $display("Something failed");
            $finish;
        end else begin
            run_stim();
            $fclose(fd);
            $display("summary: %0d checks passed, %0d checks failed", pass_count, fail_count);
            if (fail_count == 0)
                $display("Everything OK");
            else
                $display("Something failed");
            $finish;
        end
    end

endmodule

//--- verif/rv_core_stim.txt
# W off data err | R off data err | L word_addr count words... | H | T name
# all fields hex, err is the expected pslverr
R 08 00000000 0  R 0c 00000000 0  R 94 00000000 0
R 10 00000000 0  R 40 00000000 1
T after_reset
# alu program at word 0, ebreak after 16 instructions
L 00 11
00500093 ffd00113 123451b7 00208233 402082b3 00112333 001133b3 0030c433
00409493 40115513 01c15593 40115633 0090e6b3 00317733 001097b3 00708013
00100073
W 04 00000000 0  W 00 00000001 0  H
R 08 00000002 0  R 0c 00000010 0
R 80 00000000 0  R 84 00000005 0  R 88 fffffffd 0  R 8c 12345000 0
R 90 00000002 0  R 94 00000008 0  R 98 00000001 0  R 9c 00000000 0
R a0 12345005 0  R a4 00000050 0  R a8 fffffffe 0  R ac 0000000f 0
R b0 ffffffff 0  R b4 00000055 0  R b8 12345000 0  R bc 000000a0 0
T alu_program
# countdown loop, branches, jal and jalr; x3 keeps its old value
L 00 14
00300093 00000113 00210113 fff08093 fe009ce3 00008463 06300193 fff00213
00124463 04d00193 00127463 03700193 00c002ef 02c00193 00100073 04900313
000303e7 02100193 00100413 00100073
W 04 00000000 0  W 00 00000001 0  H
R 08 00000002 0  R 0c 00000013 0
R 84 00000000 0  R 88 00000006 0  R 8c 12345000 0  R 90 ffffffff 0
R 94 00000034 0  R 98 00000049 0  R 9c 00000044 0  R a0 00000001 0
T control_flow
# auipc from start pc 0xc0
L 30 3
00001497 fffff517 00100073
W 04 000000c0 0  W 00 00000001 0  H
R 04 000000c0 0  R 10 00000033 0  R 08 00000002 0  R 0c 00000002 0
R a4 000010c0 0  R a8 fffff0c4 0
T auipc_start_pc
# lw halts as illegal; loader write right after start is refused
L 38 3
00100593 00002603 00100073
W 04 000000e0 0  W 00 00000001 0  W 14 deadbeef 1  H
R 08 00000006 0  R 0c 00000001 0  R ac 00000001 0  R b0 ffffffff 0
R 10 0000003b 0
# restart on the ebreak word clears illegal
W 04 000000e8 0  W 00 00000001 0  H
R 08 00000002 0  R 0c 00000000 0
T illegal_opcode

//--- sim.f
src/rv_isa_pkg.sv
src/core_regmap_pkg.sv
src/instr_decoder.sv
src/alu.sv
src/register_file.sv
src/core_sequencer.sv
src/core_ctrl_apb.sv
src/rv_core_top.sv
verif/rv_core_assert.sv
verif/rv_core_tb.sv
